/* common/cmd_seq_pkg.sv */
// command sequencer shared definitions
package cmd_seq_pkg;

    // register port address
    typedef logic [15:0] reg_addr_t;

    localparam int CMD_MEM_BYTES = 512;

    // byte address into the command memory
    typedef logic [$clog2(CMD_MEM_BYTES)-1:0] mem_addr_t;

    // register map, 7, 8 and 13 to 15 reserved
    localparam reg_addr_t REG_SOFT_RST     = 16'd0;
    localparam reg_addr_t REG_START        = 16'd1;   // read returns finish bit
    localparam reg_addr_t REG_CONF         = 16'd2;
    localparam reg_addr_t REG_SIZE_LO      = 16'd3;
    localparam reg_addr_t REG_SIZE_HI      = 16'd4;
    localparam reg_addr_t REG_REP_LO       = 16'd5;
    localparam reg_addr_t REG_REP_HI       = 16'd6;
    localparam reg_addr_t REG_START_REP_LO = 16'd9;
    localparam reg_addr_t REG_START_REP_HI = 16'd10;
    localparam reg_addr_t REG_STOP_REP_LO  = 16'd11;
    localparam reg_addr_t REG_STOP_REP_HI  = 16'd12;
    localparam reg_addr_t REG_MEM_BASE     = 16'd16;  // command bytes from here on

    // bit positions in the configuration byte
    localparam int CONF_EXT_EN_BIT    = 0;
    localparam int CONF_MODE_LSB      = 1;            // two bits wide
    localparam int CONF_CLK_DIS_BIT   = 3;
    localparam int CONF_PULSE_DIS_BIT = 4;

    typedef enum logic [1:0] {
        MODE_NRZ        = 2'd0,
        MODE_NRZ_HALF   = 2'd1,  // nrz shifted by half a bit
        MODE_MAN_IEEE   = 2'd2,  // 0 high-low, 1 low-high
        MODE_MAN_THOMAS = 2'd3   // inverse of ieee
    } line_mode_e;

    // host request, fields held steady while req is high
    typedef struct packed {
        logic       req;
        logic       wr;
        reg_addr_t  addr;
        logic [7:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] rdata;
    } reg_rsp_t;

    // sequence configuration from the register file
    typedef struct packed {
        logic [15:0] size;        // in bits
        logic [15:0] rep_count;   // 0 behaves as 1
        logic [15:0] start_rep;
        logic [15:0] stop_rep;
        logic        ext_en;
        logic        clk_dis;
        logic        pulse_dis;
        line_mode_e  mode;
    } seq_cfg_t;

    // one cycle of a bit period
    typedef struct packed {
        logic valid;
        logic data;
        logic first;   // first of the two cycles
    } bit_sym_t;

endpackage

/* hdl/cmd_line_encoder.sv */
// serial line encoder
`timescale 1ns/1ns

module cmd_line_encoder (
    input  logic                     CMD_CLK_IN,
    input  logic                     RST_CMD_CLK,
    input  cmd_seq_pkg::bit_sym_t    sym,
    input  cmd_seq_pkg::line_mode_e  mode,
    input  logic                     clk_dis,
    output logic                     cmd_data,
    output logic                     cmd_clk_out
);
    import cmd_seq_pkg::*;

    logic prev_bit;   // last completed bit for the delayed nrz
    logic level;

    // level for the current half bit
    always_comb begin
        case (mode)
            MODE_NRZ_HALF:   level = sym.first ? prev_bit : sym.data;
            MODE_MAN_IEEE:   level = sym.first ? !sym.data : sym.data;
            MODE_MAN_THOMAS: level = sym.first ? sym.data : !sym.data;
            default:         level = sym.data;
        endcase
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            cmd_data    <= 1'b0;
            cmd_clk_out <= 1'b0;
            prev_bit    <= 1'b0;
        end else begin
            cmd_data    <= sym.valid && level;
            cmd_clk_out <= sym.valid && sym.first && !clk_dis;
            if (!sym.valid) begin
                prev_bit <= 1'b0;   // line idles low between sequences
            end else if (!sym.first) begin
                prev_bit <= sym.data;
            end
        end
    end

    // forwarded clock is one cycle high per bit
    assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        cmd_clk_out |=> !cmd_clk_out);

endmodule

/* hdl/cmd_reg_decode.sv */
// register port decode
`timescale 1ns/1ns

module cmd_reg_decode (
    input  logic                    CMD_CLK_IN,
    input  logic                    RST_CMD_CLK,
    input  cmd_seq_pkg::reg_req_t   reg_req,
    output cmd_seq_pkg::reg_rsp_t   reg_rsp,
    input  logic                    cmd_ext_start_flag,
    output logic                    cmd_ext_start_enable,
    input  logic                    seq_ready,
    output cmd_seq_pkg::seq_cfg_t   cfg,
    output logic                    seq_start,
    output logic                    seq_abort,
    output logic                    mem_wr,
    output logic                    mem_rd,
    output cmd_seq_pkg::mem_addr_t  mem_addr,
    output logic [7:0]              mem_wdata,
    input  logic [7:0]              mem_rdata
);
    import cmd_seq_pkg::*;

    logic        ack;
    logic        access;      // first cycle of a request
    logic        wr_access;
    logic        in_mem;
    logic        soft_rst;
    logic        sel_mem;     // read-back taken from memory
    logic [7:0]  reg_rdata;
    logic [7:0]  conf;
    logic [15:0] size;
    logic [15:0] rep;
    logic [15:0] start_rep;
    logic [15:0] stop_rep;
    logic        finish;
    logic        ready_d;

    assign access    = reg_req.req && !ack;
    assign wr_access = access && reg_req.wr;
    assign soft_rst  = wr_access && (reg_req.addr == REG_SOFT_RST);
    assign in_mem    = (reg_req.addr >= REG_MEM_BASE) &&
                       (reg_req.addr < REG_MEM_BASE + CMD_MEM_BYTES);

    // memory read register lines up with ack
    assign mem_addr  = mem_addr_t'(reg_req.addr - REG_MEM_BASE);
    assign mem_wdata = reg_req.wdata;
    assign mem_wr    = wr_access && in_mem;
    assign mem_rd    = access && !reg_req.wr && in_mem;

    // ack trails req by one cycle on both edges
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            ack <= 1'b0;
        end else begin
            ack <= reg_req.req;
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            conf      <= '0;
            size      <= '0;
            rep       <= 16'd1;   // single pass
            start_rep <= '0;
            stop_rep  <= '0;
        end else if (wr_access) begin
            case (reg_req.addr)
                REG_CONF:         conf            <= reg_req.wdata;
                REG_SIZE_LO:      size[7:0]       <= reg_req.wdata;
                REG_SIZE_HI:      size[15:8]      <= reg_req.wdata;
                REG_REP_LO:       rep[7:0]        <= reg_req.wdata;
                REG_REP_HI:       rep[15:8]       <= reg_req.wdata;
                REG_START_REP_LO: start_rep[7:0]  <= reg_req.wdata;
                REG_START_REP_HI: start_rep[15:8] <= reg_req.wdata;
                REG_STOP_REP_LO:  stop_rep[7:0]   <= reg_req.wdata;
                REG_STOP_REP_HI:  stop_rep[15:8]  <= reg_req.wdata;
                default: ;
            endcase
        end
    end

    assign cfg = '{
        size:      size,
        rep_count: rep,
        start_rep: start_rep,
        stop_rep:  stop_rep,
        ext_en:    conf[CONF_EXT_EN_BIT],
        clk_dis:   conf[CONF_CLK_DIS_BIT],
        pulse_dis: conf[CONF_PULSE_DIS_BIT],
        mode:      line_mode_e'(conf[CONF_MODE_LSB +: 2])
    };
    assign cmd_ext_start_enable = cfg.ext_en;

    // start from register write or gated external flag
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            seq_start <= 1'b0;
            seq_abort <= 1'b0;
        end else begin
            seq_start <= (wr_access && reg_req.addr == REG_START) ||
                         (cmd_ext_start_flag && cfg.ext_en);
            seq_abort <= soft_rst;
        end
    end

    // finish bit cleared on an accepted start and set when ready comes back
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            finish  <= 1'b1;
            ready_d <= 1'b1;
        end else begin
            ready_d <= seq_ready;
            if (seq_start && seq_ready) begin
                finish <= 1'b0;
            end else if (seq_ready && !ready_d) begin
                finish <= 1'b1;
            end
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (access) begin
            sel_mem <= in_mem && !reg_req.wr;
            case (reg_req.addr)
                REG_START:        reg_rdata <= {7'b0, finish};
                REG_CONF:         reg_rdata <= conf;
                REG_SIZE_LO:      reg_rdata <= size[7:0];
                REG_SIZE_HI:      reg_rdata <= size[15:8];
                REG_REP_LO:       reg_rdata <= rep[7:0];
                REG_REP_HI:       reg_rdata <= rep[15:8];
                REG_START_REP_LO: reg_rdata <= start_rep[7:0];
                REG_START_REP_HI: reg_rdata <= start_rep[15:8];
                REG_STOP_REP_LO:  reg_rdata <= stop_rep[7:0];
                REG_STOP_REP_HI:  reg_rdata <= stop_rep[15:8];
                default:          reg_rdata <= 8'h00;   // reserved and out of range
            endcase
        end
    end

    assign reg_rsp = '{
        ack:   ack,
        rdata: ack ? (sel_mem ? mem_rdata : reg_rdata) : 8'h00
    };

    // host keeps req up until it has seen ack
    assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        $fell(reg_req.req) |-> ack);

endmodule

/* hdl/cmd_seq_top.sv */
// command sequencer top
`timescale 1ns/1ns

module cmd_seq_top (
    input  logic                   CMD_CLK_IN,
    input  logic                   RST_CMD_CLK,
    input  cmd_seq_pkg::reg_req_t  reg_req,
    output cmd_seq_pkg::reg_rsp_t  reg_rsp,
    input  logic                   cmd_ext_start_flag,
    output logic                   cmd_ext_start_enable,
    output logic                   cmd_data,
    output logic                   cmd_clk_out,
    output logic                   cmd_ready,
    output logic                   cmd_start_flag
);
    import cmd_seq_pkg::*;

    seq_cfg_t   cfg;
    logic       seq_start;
    logic       seq_abort;
    logic       host_wr;
    logic       host_rd;
    mem_addr_t  host_addr;
    logic [7:0] host_wdata;
    logic [7:0] host_rdata;
    mem_addr_t  seq_addr;
    logic [7:0] seq_rdata;
    bit_sym_t   sym;

    cmd_reg_decode u_decode (
        .CMD_CLK_IN           (CMD_CLK_IN),
        .RST_CMD_CLK          (RST_CMD_CLK),
        .reg_req              (reg_req),
        .reg_rsp              (reg_rsp),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .cmd_ext_start_enable (cmd_ext_start_enable),
        .seq_ready            (cmd_ready),
        .cfg                  (cfg),
        .seq_start            (seq_start),
        .seq_abort            (seq_abort),
        .mem_wr               (host_wr),
        .mem_rd               (host_rd),
        .mem_addr             (host_addr),
        .mem_wdata            (host_wdata),
        .mem_rdata            (host_rdata)
    );

    cmd_seq_ctrl u_ctrl (
        .CMD_CLK_IN     (CMD_CLK_IN),
        .RST_CMD_CLK    (RST_CMD_CLK),
        .cfg            (cfg),
        .seq_start      (seq_start),
        .seq_abort      (seq_abort),
        .rd_addr        (seq_addr),
        .rd_data        (seq_rdata),
        .sym            (sym),
        .cmd_ready      (cmd_ready),
        .cmd_start_flag (cmd_start_flag)
    );

    cmd_seq_mem u_mem (
        .CMD_CLK_IN (CMD_CLK_IN),
        .host_wr    (host_wr),
        .host_rd    (host_rd),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .seq_addr   (seq_addr),
        .seq_rdata  (seq_rdata)
    );

    cmd_line_encoder u_encoder (
        .CMD_CLK_IN  (CMD_CLK_IN),
        .RST_CMD_CLK (RST_CMD_CLK),
        .sym         (sym),
        .mode        (cfg.mode),
        .clk_dis     (cfg.clk_dis),
        .cmd_data    (cmd_data),
        .cmd_clk_out (cmd_clk_out)
    );

endmodule

/* list.f */
+incdir+verification
common/cmd_seq_pkg.sv
sequencer/cmd_seq_mem.sv
sequencer/cmd_seq_ctrl.sv
hdl/cmd_reg_decode.sv
hdl/cmd_line_encoder.sv
hdl/cmd_seq_top.sv
verification/cmd_seq_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the command sequencer testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f list.f \
    --top-module cmd_seq_tb

./obj_dir/Vcmd_seq_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"

/* sequencer/cmd_seq_ctrl.sv */
// command sequence controller
`timescale 1ns/1ns

module cmd_seq_ctrl (
    input  logic                    CMD_CLK_IN,
    input  logic                    RST_CMD_CLK,
    input  cmd_seq_pkg::seq_cfg_t   cfg,
    input  logic                    seq_start,
    input  logic                    seq_abort,
    output cmd_seq_pkg::mem_addr_t  rd_addr,
    input  logic [7:0]              rd_data,
    output cmd_seq_pkg::bit_sym_t   sym,
    output logic                    cmd_ready,
    output logic                    cmd_start_flag
);
    import cmd_seq_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_TAIL
    } state_e;

    state_e      state;
    logic        half;        // second cycle of the bit
    logic [15:0] bit_idx;
    logic [15:0] next_idx;
    logic [15:0] pass_cnt;    // finished middle passes
    logic [15:0] rep_total;
    logic [15:0] mid_last;    // last bit of the middle section
    logic        go;
    logic        bit_end;
    logic        wrap;
    logic        seq_end;

    assign go        = (state == ST_IDLE) && cmd_ready && seq_start;
    assign rep_total = (cfg.rep_count == 16'd0) ? 16'd1 : cfg.rep_count;
    assign mid_last  = cfg.size - cfg.stop_rep - 16'd1;
    assign bit_end   = (state == ST_SEND) && half;

    // back to start_rep while passes remain, else on to the suffix
    assign wrap    = (bit_idx == mid_last) && (pass_cnt != rep_total - 16'd1);
    assign seq_end = !wrap && (bit_idx == cfg.size - 16'd1);

    always_comb begin
        next_idx = bit_idx;
        if (state != ST_SEND) begin
            next_idx = '0;
        end else if (bit_end) begin
            if (wrap) begin
                next_idx = cfg.start_rep;
            end else if (seq_end) begin
                next_idx = '0;
            end else begin
                next_idx = bit_idx + 16'd1;
            end
        end
    end

    // address the byte of the upcoming bit, data lands one cycle later
    assign rd_addr = mem_addr_t'(next_idx >> 3);

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || seq_abort) begin
            state     <= ST_IDLE;
            half      <= 1'b0;
            bit_idx   <= '0;
            pass_cnt  <= '0;
            cmd_ready <= 1'b1;
        end else begin
            bit_idx <= next_idx;
            case (state)
                ST_IDLE: begin
                    half      <= 1'b0;
                    cmd_ready <= !go;   // ready comes back one cycle into idle
                    if (go) begin
                        state    <= ST_SEND;
                        pass_cnt <= '0;
                    end
                end
                ST_SEND: begin
                    half <= !half;
                    if (bit_end && wrap) begin
                        pass_cnt <= pass_cnt + 16'd1;
                    end
                    if (bit_end && seq_end) begin
                        state <= ST_TAIL;
                    end
                end
                ST_TAIL: state <= ST_IDLE;   // lets the encoder drain
                default: state <= ST_IDLE;
            endcase
        end
    end

    // registered so it lines up with the encoded line
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            cmd_start_flag <= 1'b0;
        end else begin
            cmd_start_flag <= (state == ST_SEND) && !half && (pass_cnt == 16'd0) &&
                              (bit_idx == cfg.start_rep) && !cfg.pulse_dis;
        end
    end

    assign sym = '{
        valid: state == ST_SEND,
        data:  rd_data[3'd7 - bit_idx[2:0]],   // msb first
        first: (state == ST_SEND) && !half
    };

    assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK)
        !(cmd_ready && sym.valid));

    // config is cleared together with the abort pulse
    assert property (@(posedge CMD_CLK_IN) disable iff (RST_CMD_CLK || seq_abort)
        sym.valid |-> bit_idx < cfg.size);

endmodule

/* sequencer/cmd_seq_mem.sv */
// command pattern memory
`timescale 1ns/1ns

module cmd_seq_mem (
    input  logic                    CMD_CLK_IN,
    input  logic                    host_wr,
    input  logic                    host_rd,
    input  cmd_seq_pkg::mem_addr_t  host_addr,
    input  logic [7:0]              host_wdata,
    output logic [7:0]              host_rdata,
    input  cmd_seq_pkg::mem_addr_t  seq_addr,
    output logic [7:0]              seq_rdata
);
    import cmd_seq_pkg::*;

    logic [7:0] mem [CMD_MEM_BYTES];

    // host side, write or read per access
    always_ff @(posedge CMD_CLK_IN) begin
        if (host_wr) begin
            mem[host_addr] <= host_wdata;
        end
        if (host_rd) begin
            host_rdata <= mem[host_addr];   // held until the next read
        end
    end

    // sequencer side reads every cycle
    always_ff @(posedge CMD_CLK_IN) begin
        seq_rdata <= mem[seq_addr];
    end

endmodule

/* verification/cmd_seq_model.svh */
// command stream reference model
`ifndef CMD_SEQ_MODEL_SVH
`define CMD_SEQ_MODEL_SVH

logic [7:0] pattern [CMD_MEM_BYTES];   // host copy of the command memory
bit         exp_bits [$];

// memory bits run byte by byte, msb first
function automatic bit pattern_bit(int k);
    return pattern[k / 8][7 - (k % 8)];
endfunction

// prefix once, middle r times, suffix once
function automatic void build_stream(int n, int s, int p, int r);
    int passes;
    int k;
    exp_bits.delete();
    passes = (r == 0) ? 1 : r;   // zero repeats means one pass
    for (k = 0; k < s; k++) begin
        exp_bits.push_back(pattern_bit(k));
    end
    repeat (passes) begin
        for (k = s; k < n - p; k++) begin
            exp_bits.push_back(pattern_bit(k));
        end
    end
    for (k = n - p; k < n; k++) begin
        exp_bits.push_back(pattern_bit(k));
    end
endfunction

// two half-bit samples back to one bit, ok drops on a code violation
function automatic void decode_halves(input line_mode_e mode, input bit h0, input bit h1,
                                      input bit prev, output bit b, output bit ok);
    case (mode)
        MODE_NRZ: begin
            b  = h0;
            ok = (h0 == h1);
        end
        MODE_NRZ_HALF: begin
            b  = h1;
            ok = (h0 == prev);   // first half still carries the last bit
        end
        MODE_MAN_IEEE: begin
            b  = h1;             // 1 is low then high
            ok = (h0 != h1);
        end
        default: begin
            b  = h0;             // thomas, 1 is high then low
            ok = (h0 != h1);
        end
    endcase
endfunction

`endif

/* verification/cmd_seq_tb.sv */
// command sequencer testbench
`timescale 1ns/1ns

module cmd_seq_tb;
    import cmd_seq_pkg::*;

    logic        CMD_CLK_IN;
    logic        RST_CMD_CLK;
    reg_req_t    reg_req;
    reg_rsp_t    reg_rsp;
    logic        cmd_ext_start_flag;
    logic        cmd_ext_start_enable;
    logic        cmd_data;
    logic        cmd_clk_out;
    logic        cmd_ready;
    logic        cmd_start_flag;

    logic [31:0] lcg_state = 32'hb32d;
    int unsigned cycles = 0;
    int unsigned budget = 20;   // covers reset
    string       cur_test = "reset";
    int          test_errs;
    int          total_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cfg_n;
    int          cfg_s;
    int          cfg_p;
    int          cfg_r;
    logic [7:0]  cfg_conf;
    bit          got_bits [$];
    int          flag_count;
    int          flag_pos;
    int          code_errs;

    `include "cmd_seq_model.svh"

    cmd_seq_top DUT (
        .CMD_CLK_IN           (CMD_CLK_IN),
        .RST_CMD_CLK          (RST_CMD_CLK),
        .reg_req              (reg_req),
        .reg_rsp              (reg_rsp),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .cmd_ext_start_enable (cmd_ext_start_enable),
        .cmd_data             (cmd_data),
        .cmd_clk_out          (cmd_clk_out),
        .cmd_ready            (cmd_ready),
        .cmd_start_flag       (cmd_start_flag)
    );

    initial begin
        CMD_CLK_IN = 1'b0;
        forever #4 CMD_CLK_IN = ~CMD_CLK_IN;
    end

    // limit grows as each test adds its share
    always @(posedge CMD_CLK_IN) begin
        cycles++;
        if (cycles > budget) begin
            $display("timeout in test %s after %0d cycles", cur_test, cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic int unsigned rand_below(int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % n;
    endfunction

    task automatic expect_equal(input string what, input int exp, input int got);
        assert (exp == got) else begin
            $display("error %s %s: expected %0d, got %0d", cur_test, what, exp, got);
            test_errs++;
        end
    endtask

    task automatic must_hold(input bit cond, input string what);
        assert (cond) else begin
            $display("%s: %s", cur_test, what);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
        budget   += 200;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s ok", cur_test);
        end else begin
            $display("test %s failed with %0d errors", cur_test, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        tests_run++;
    endtask

    // four-phase access called and returning on a falling edge
    task automatic reg_access(input logic wr, input reg_addr_t addr, input logic [7:0] wdata,
                              output logic [7:0] rdata);
        int waited;
        waited  = 0;
        reg_req = '{req: 1'b1, wr: wr, addr: addr, wdata: wdata};
        do begin
            @(negedge CMD_CLK_IN);
            waited++;
        end while (!reg_rsp.ack && waited < 8);
        must_hold(reg_rsp.ack, $sformatf("no ack for access to address %0d", addr));
        rdata       = reg_rsp.rdata;
        reg_req.req = 1'b0;
        waited      = 0;
        do begin
            @(negedge CMD_CLK_IN);
            waited++;
        end while (reg_rsp.ack && waited < 8);
        must_hold(!reg_rsp.ack, "ack stayed high after req fell");
    endtask

    task automatic write_word(input reg_addr_t lo_addr, input int value);
        logic [7:0] rd;
        reg_access(1'b1, lo_addr, value[7:0], rd);
        reg_access(1'b1, lo_addr + 16'd1, value[15:8], rd);
    endtask

    task automatic pulse_ext_start();
        cmd_ext_start_flag = 1'b1;
        @(negedge CMD_CLK_IN);
        cmd_ext_start_flag = 1'b0;
    endtask

    task automatic sample_half(output bit h);
        h = cmd_data;
        if (cmd_start_flag) begin
            flag_count++;
            flag_pos = got_bits.size();   // index of the bit on the line
        end
    endtask

    // random valid config, pattern and expected stream
    task automatic setup_sequence(input line_mode_e mode, input logic clk_dis,
                                  input logic pulse_dis, input logic ext_en,
                                  input int n_min, input int n_span, input int r_max);
        logic [7:0] rd;
        int k;
        cfg_n = n_min + rand_below(n_span);
        cfg_s = rand_below(cfg_n);
        cfg_p = rand_below(cfg_n - cfg_s);   // keeps s + p below n
        cfg_r = rand_below(r_max + 1);
        for (k = 0; k < (cfg_n + 7) / 8; k++) begin
            pattern[k] = 8'(rand_below(256));
            reg_access(1'b1, reg_addr_t'(REG_MEM_BASE + k), pattern[k], rd);
        end
        write_word(REG_SIZE_LO, cfg_n);
        write_word(REG_REP_LO, cfg_r);
        write_word(REG_START_REP_LO, cfg_s);
        write_word(REG_STOP_REP_LO, cfg_p);
        cfg_conf = {3'b000, pulse_dis, clk_dis, mode, ext_en};
        reg_access(1'b1, REG_CONF, cfg_conf, rd);
        build_stream(cfg_n, cfg_s, cfg_p, cfg_r);
        budget += 2 * exp_bits.size();
    endtask

    // line decoder from the fall of cmd_ready until it rises again
    task automatic collect_stream(input line_mode_e mode, input logic clk_dis);
        bit h0;
        bit h1;
        bit b;
        bit ok;
        bit prev;
        got_bits.delete();
        flag_count = 0;
        flag_pos   = -1;
        code_errs  = 0;
        prev       = 1'b0;   // line idles low
        while (cmd_ready) begin
            @(negedge CMD_CLK_IN);
        end
        forever begin
            @(negedge CMD_CLK_IN);
            if (cmd_ready) break;
            if (clk_dis || cmd_clk_out) begin   // fixed 2-cycle steps without a clock
                must_hold(cmd_clk_out == !clk_dis, "forwarded clock wrong at a bit start");
                sample_half(h0);
                @(negedge CMD_CLK_IN);
                if (cmd_ready) break;
                must_hold(!cmd_clk_out, "forwarded clock high in the second half of a bit");
                sample_half(h1);
                decode_halves(mode, h0, h1, prev, b, ok);
                code_errs += ok ? 0 : 1;
                got_bits.push_back(b);
                prev = b;
            end else begin
                sample_half(h0);
            end
        end
        @(negedge CMD_CLK_IN);   // finish bit trails ready by a cycle
    endtask

    task automatic check_stream(input logic pulse_dis);
        logic [7:0] rd;
        int k;
        expect_equal("stream length", exp_bits.size(), got_bits.size());
        for (k = 0; k < exp_bits.size() && k < got_bits.size(); k++) begin
            if (got_bits[k] != exp_bits[k]) begin
                expect_equal($sformatf("bit %0d", k), exp_bits[k], got_bits[k]);
                break;
            end
        end
        expect_equal("line code violations", 0, code_errs);
        expect_equal("start flag pulses", pulse_dis ? 0 : 1, flag_count);
        if (!pulse_dis && flag_count == 1) begin
            expect_equal("start flag bit", cfg_s, flag_pos);
        end
        reg_access(1'b0, REG_START, 8'h00, rd);
        expect_equal("finish bit", 1, rd);
    endtask

    task automatic test_registers();
        logic [7:0] val;
        logic [7:0] rd;
        reg_addr_t addr;
        int a;
        int k;
        start_test("registers");
        reg_access(1'b0, REG_START, 8'h00, rd);
        expect_equal("finish after reset", 1, rd);
        for (a = REG_CONF; a <= 15; a++) begin
            val = 8'(rand_below(256));
            reg_access(1'b1, reg_addr_t'(a), val, rd);
            reg_access(1'b0, reg_addr_t'(a), 8'h00, rd);
            expect_equal($sformatf("register %0d", a), (a == 7 || a == 8 || a > 12) ? 0 : val, rd);
        end
        for (k = 0; k < 4; k++) begin
            addr = reg_addr_t'(REG_MEM_BASE + k * 128 + rand_below(128));
            val  = 8'(rand_below(256));
            reg_access(1'b1, addr, val, rd);
            reg_access(1'b0, addr, 8'h00, rd);
            expect_equal($sformatf("memory byte %0d", addr - REG_MEM_BASE), val, rd);
        end
        addr = reg_addr_t'(REG_MEM_BASE + CMD_MEM_BYTES);   // first address past the memory
        reg_access(1'b1, addr, 8'h5a, rd);
        reg_access(1'b0, addr, 8'h00, rd);
        expect_equal("out of range read", 0, rd);
        end_test();
    endtask

    task automatic test_sequence(input line_mode_e mode, input logic clk_dis,
                                 input logic pulse_dis, input int idx);
        logic [7:0] rd;
        start_test($sformatf("seq%0d_mode%0d", idx, mode));
        setup_sequence(mode, clk_dis, pulse_dis, 1'b0, 1, 96, 3);
        reg_access(1'b1, REG_START, 8'h01, rd);
        collect_stream(mode, clk_dis);
        check_stream(pulse_dis);
        end_test();
    endtask

    task automatic test_ext_start();
        logic [7:0] rd;
        start_test("ext_start");
        setup_sequence(MODE_MAN_IEEE, 1'b0, 1'b0, 1'b0, 1, 64, 2);
        expect_equal("ext enable off", 0, cmd_ext_start_enable);
        pulse_ext_start();
        repeat (4) begin
            @(negedge CMD_CLK_IN);
            must_hold(cmd_ready, "external flag started a sequence while disabled");
        end
        reg_access(1'b1, REG_CONF, cfg_conf | 8'h01, rd);
        expect_equal("ext enable on", 1, cmd_ext_start_enable);
        pulse_ext_start();
        collect_stream(MODE_MAN_IEEE, 1'b0);
        check_stream(1'b0);
        end_test();
    endtask

    task automatic test_soft_reset();
        logic [7:0] rd;
        int a;
        start_test("soft_reset");
        setup_sequence(MODE_NRZ, 1'b0, 1'b0, 1'b1, 64, 32, 3);
        reg_access(1'b1, REG_START, 8'h01, rd);
        repeat (20) @(negedge CMD_CLK_IN);
        must_hold(!cmd_ready, "sequence not running before the soft reset");
        reg_access(1'b1, REG_SOFT_RST, 8'h01, rd);
        must_hold(cmd_ready, "cmd_ready did not return after the soft reset");
        expect_equal("ext enable after reset", 0, cmd_ext_start_enable);
        for (a = REG_CONF; a <= REG_STOP_REP_HI; a++) begin
            reg_access(1'b0, reg_addr_t'(a), 8'h00, rd);
            expect_equal($sformatf("default of register %0d", a), (a == REG_REP_LO) ? 1 : 0, rd);
        end
        end_test();
    endtask

    initial begin
        int i;
        reg_req            = '0;
        cmd_ext_start_flag = 1'b0;
        RST_CMD_CLK        = 1'b1;
        repeat (10) @(negedge CMD_CLK_IN);
        RST_CMD_CLK = 1'b0;
        test_registers();
        for (i = 0; i < 8; i++) begin
            test_sequence(line_mode_e'(i % 4), i >= 4, i == 3 || i == 6, i);
        end
        test_ext_start();
        test_soft_reset();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
